// File: Makefile
VERILATOR ?= verilator
TOP       ?= rtx_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
hw/rtx_pkg.sv
hw/fp24_mul.sv
hw/fp24_add.sv
hw/ray_caster.sv
hw/ray_tracer.sv
hw/pixel_packer.sv
hw/rtx.sv
sim/clock_gen.sv
sim/rtx_tb.sv

// File: sim/rtx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rtx_tb;
  import rtx_pkg::*;

  localparam int TIMEOUT_CYCLES = 2 * SCREEN_W * SCREEN_H * (SCENE_DEPTH * 40 + 10);
  localparam int FRAMES = 2;
  localparam logic [31:0] SEED = 32'h1d7a3779;

  logic                    clk;
  logic                    rst;
  logic [15:0]             rtx_pixel;
  logic [PIX_H_BITS-1:0]   pixel_h;
  logic [PIX_V_BITS-1:0]   pixel_v;
  logic                    ray_done;
  logic [OBJ_IDX_BITS-1:0] obj_idx;
  fp24_vec3_t              obj_center;
  fp24_t                   obj_radius_sq;
  fp24_color_t             obj_color;
  logic                    obj_last;

  // Scene 0 feeds frame 1 and scene 1 feeds frame 2
  real sc_cx[2][SCENE_DEPTH];
  real sc_cy[2][SCENE_DEPTH];
  real sc_cz[2][SCENE_DEPTH];
  real sc_r2[2][SCENE_DEPTH];
  real sc_cr[2][SCENE_DEPTH];
  real sc_cg[2][SCENE_DEPTH];
  real sc_cb[2][SCENE_DEPTH];
  int  sc_last[2];

  int                      scene_sel = 0;
  int                      frame_no = 0;
  int                      exp_h = 0;
  int                      exp_v = 0;
  int                      cycles = 0;
  int                      seen[4];
  logic [OBJ_IDX_BITS-1:0] idx_sampled = '0;
  logic [OBJ_IDX_BITS-1:0] idx_prev = '0;
  logic                    done_prev = 1'b0;

  clock_gen clock (.clk(clk), .rst(rst));

  rtx dut (
    .clk(clk),
    .rst(rst),
    .rtx_pixel(rtx_pixel),
    .pixel_h(pixel_h),
    .pixel_v(pixel_v),
    .ray_done(ray_done),
    .obj_idx(obj_idx),
    .obj_center(obj_center),
    .obj_radius_sq(obj_radius_sq),
    .obj_color(obj_color),
    .obj_last(obj_last)
  );

  task automatic abort_run(input string what);
    $display("[ERROR] %s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input int expected, input int actual);
    $display("[ERROR] %s: expected 'h%0h, actual 'h%0h", test, expected, actual);
    $display("Test failed");
    $fatal(1);
  endtask

  // Real to fp24 with the fraction truncated
  function automatic fp24_t to_fp24(input real v);
    real         m;
    int          e;
    logic        sgn;
    logic [15:0] frac;
    if (v == 0.0) begin
      return '0;
    end
    sgn = (v < 0.0);
    m = sgn ? -v : v;
    e = 63;
    while (m >= 2.0) begin
      m = m / 2.0;
      e++;
    end
    while (m < 1.0) begin
      m = m * 2.0;
      e--;
    end
    frac = 16'($rtoi((m - 1.0) * 65536.0));
    return {sgn, 7'(e), frac};
  endfunction

  function automatic real from_fp24(input fp24_t f);
    real m;
    int  e;
    if (f[22:16] == 7'd0) begin
      return 0.0;
    end
    m = 1.0 + real'(f[15:0]) / 65536.0;
    for (e = int'(f[22:16]); e > 63; e--) begin
      m = m * 2.0;
    end
    for (e = int'(f[22:16]); e < 63; e++) begin
      m = m / 2.0;
    end
    return f[23] ? -m : m;
  endfunction

  // Clip to [0, 1] and take floor(v * 2^bits) saturated
  function automatic int to_field(input real v, input int bits);
    real c;
    int  n;
    c = (v < 0.0) ? 0.0 : ((v > 1.0) ? 1.0 : v);
    n = $rtoi(c * real'(1 << bits));
    if (n > (1 << bits) - 1) begin
      n = (1 << bits) - 1;
    end
    return n;
  endfunction

  // Returns 0 for a miss, 1 for a hit and 2 when too close to the edge to call
  function automatic int classify(input int sc, input int i, input real dx, input real dy,
                                  input real dz);
    real b, dd, cc, lhs, rhs, big;
    b = sc_cx[sc][i] * dx + sc_cy[sc][i] * dy + sc_cz[sc][i] * dz;
    if (b <= 0.0) begin
      return 0;
    end
    dd = dx * dx + dy * dy + dz * dz;
    cc = sc_cx[sc][i] ** 2 + sc_cy[sc][i] ** 2 + sc_cz[sc][i] ** 2 - sc_r2[sc][i];
    lhs = b * b;
    rhs = dd * cc;
    big = lhs + ((rhs < 0.0) ? -rhs : rhs);
    if ((lhs - rhs) < 0.01 * big && (rhs - lhs) < 0.01 * big) begin
      return 2;
    end
    return (lhs >= rhs) ? 1 : 0;
  endfunction

  function automatic string category_name(input int cat);
    case (cat)
      0: return "background_miss";
      1: return "scene_a_hit";
      2: return "scene_b_overlap_red";
      default: return "scene_b_outer_green";
    endcase
  endfunction

  task automatic predict(input int sc, input int h, input int v, output logic [15:0] pixel,
                         output bit unsure, output int hit_obj);
    real dx, dy, dz, r, g, b;
    int  cls;
    dx = real'(h - SCREEN_W / 2);
    dy = real'(SCREEN_H / 2 - v);
    dz = real'(SCREEN_W / 2);
    r = from_fp24(BACKGROUND.r);
    g = from_fp24(BACKGROUND.g);
    b = from_fp24(BACKGROUND.b);
    unsure = 1'b0;
    hit_obj = -1;
    for (int i = 0; i <= sc_last[sc]; i++) begin
      if (hit_obj < 0) begin
        cls = classify(sc, i, dx, dy, dz);
        if (cls == 2) begin
          unsure = 1'b1;
        end
        if (cls == 1) begin
          hit_obj = i;
          r = sc_cr[sc][i];
          g = sc_cg[sc][i];
          b = sc_cb[sc][i];
        end
      end
    end
    pixel = {5'(to_field(b, 5)), 6'(to_field(g, 6)), 5'(to_field(r, 5))};
  endtask

  task automatic place_sphere(input int sc, input int i, input real x, input real y,
                              input real z, input real r2, input real cr, input real cg,
                              input real cb);
    sc_cx[sc][i] = x;
    sc_cy[sc][i] = y;
    sc_cz[sc][i] = z;
    sc_r2[sc][i] = r2;
    sc_cr[sc][i] = cr;
    sc_cg[sc][i] = cg;
    sc_cb[sc][i] = cb;
  endtask

  task automatic load_scenes();
    real side;
    for (int sc = 0; sc < 2; sc++) begin
      for (int i = 0; i < SCENE_DEPTH; i++) begin
        place_sphere(sc, i, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0);
      end
    end
    // Scene A has a big sphere on the axis and one far off to the side
    side = ($urandom_range(0, 1) == 1) ? 1.0 : -1.0;
    place_sphere(0, 0, 0.0, 0.0, 40.0, 400.0, 2.0, 0.5, 0.0);
    place_sphere(0, 1, side * real'(200 + $urandom_range(0, 99)),
                 real'($urandom_range(0, 160)) - 80.0, real'($urandom_range(10, 60)),
                 real'($urandom_range(1, 16)), 0.5, 0.5, 0.5);
    sc_last[0] = 1;
    // Scene B has a small red sphere in front of a larger green one
    place_sphere(1, 0, 0.0, 0.0, 30.0, 64.0, 1.0, 0.0, 0.0);
    place_sphere(1, 1, 0.0, 0.0, 40.0, 625.0, 0.0, 1.0, 0.0);
    sc_last[1] = 1;
  endtask

  task automatic handle_pixel();
    logic [15:0] want;
    bit          unsure;
    int          hit_obj;
    int          cat;
    int          missing;
    assert (int'(pixel_h) == exp_h) else report_mismatch("raster_h", exp_h, int'(pixel_h));
    assert (int'(pixel_v) == exp_v) else report_mismatch("raster_v", exp_v, int'(pixel_v));
    assert (obj_idx == '0) else report_mismatch("obj_idx_restart", 0, int'(obj_idx));
    predict(scene_sel, exp_h, exp_v, want, unsure, hit_obj);
    cat = (hit_obj < 0) ? 0 : ((scene_sel == 0) ? 1 : 2 + hit_obj);
    if (!unsure) begin
      seen[cat]++;
      assert (rtx_pixel == want)
        else report_mismatch(category_name(cat), int'(want), int'(rtx_pixel));
    end
    if (exp_h == SCREEN_W - 1) begin
      exp_h = 0;
      exp_v = (exp_v == SCREEN_H - 1) ? 0 : exp_v + 1;
    end else begin
      exp_h++;
    end
    // Frame is complete once the raster wraps
    if (exp_h == 0 && exp_v == 0) begin
      frame_no++;
      scene_sel = 1;
      if (frame_no == FRAMES) begin
        missing = -1;
        for (int k = 3; k >= 0; k--) begin
          if (seen[k] == 0) begin
            missing = k;
          end
        end
        if (missing < 0) begin
          $display("Test passed");
          $finish;
        end else begin
          abort_run($sformatf("no %s pixel was checked", category_name(missing)));
        end
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    obj_center = '0;
    obj_radius_sq = '0;
    obj_color = '0;
    obj_last = 1'b0;
    for (int k = 0; k < 4; k++) begin
      seen[k] = 0;
    end
    load_scenes();
  end

  // Scene buffer takes the index before the edge and answers 1 ns after it
  always @(negedge clk) begin
    idx_sampled = $isunknown(obj_idx) ? '0 : obj_idx;
  end

  always @(posedge clk) begin
    #1;
    obj_center.x = to_fp24(sc_cx[scene_sel][idx_sampled]);
    obj_center.y = to_fp24(sc_cy[scene_sel][idx_sampled]);
    obj_center.z = to_fp24(sc_cz[scene_sel][idx_sampled]);
    obj_radius_sq = to_fp24(sc_r2[scene_sel][idx_sampled]);
    obj_color.r = to_fp24(sc_cr[scene_sel][idx_sampled]);
    obj_color.g = to_fp24(sc_cg[scene_sel][idx_sampled]);
    obj_color.b = to_fp24(sc_cb[scene_sel][idx_sampled]);
    obj_last = (int'(idx_sampled) == sc_last[scene_sel]);
  end

  always @(negedge clk) begin
    if (!rst) begin
      assert (!$isunknown(ray_done)) else abort_run("ray_done is unknown after reset");
      assert (!(ray_done && done_prev)) else abort_run("ray_done was high two cycles in a row");
      assert (obj_idx == idx_prev || int'(obj_idx) == int'(idx_prev) + 1 || obj_idx == '0)
        else report_mismatch("obj_idx_step", int'(idx_prev) + 1, int'(obj_idx));
      assert (int'(obj_idx) <= sc_last[scene_sel])
        else report_mismatch("obj_idx_last", sc_last[scene_sel], int'(obj_idx));
      done_prev = ray_done;
      idx_prev = obj_idx;
      if (ray_done) begin
        handle_pixel();
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run("timed out before two full frames of pixels came out");
    end
  end

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);
  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release a little after the edge, like the rest of the stimulus
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: hw/rtx.sv
`timescale 1ns/1ps
`default_nettype none

module rtx (
  input  wire clk,
  input  wire rst,
  output logic [15:0] rtx_pixel,
  output logic [rtx_pkg::PIX_H_BITS-1:0] pixel_h,
  output logic [rtx_pkg::PIX_V_BITS-1:0] pixel_v,
  output logic ray_done,
  // Scene buffer, registered read
  output logic [rtx_pkg::OBJ_IDX_BITS-1:0] obj_idx,
  input  wire rtx_pkg::fp24_vec3_t obj_center,
  input  wire rtx_pkg::fp24_t obj_radius_sq,
  input  wire rtx_pkg::fp24_color_t obj_color,
  input  wire obj_last
);
  import rtx_pkg::*;

  logic                  rst_q;
  logic                  new_ray;
  logic [PIX_H_BITS-1:0] cast_h, trace_h;
  logic [PIX_V_BITS-1:0] cast_v, trace_v;
  fp24_vec3_t            ray_dir;
  logic                  ray_valid;
  logic                  trace_done;
  fp24_color_t           color;

  always_ff @(posedge clk) begin
    rst_q <= rst;
  end

  // Kick off on reset release, then one ray per finished pixel
  assign new_ray = (rst_q && !rst) || ray_done;

  ray_caster caster (
    .clk(clk),
    .rst(rst),
    .new_ray(new_ray),
    .pix_h(cast_h),
    .pix_v(cast_v),
    .ray_dir(ray_dir),
    .ray_valid(ray_valid)
  );

  ray_tracer tracer (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .pix_h_in(cast_h),
    .pix_v_in(cast_v),
    .ray_dir(ray_dir),
    .obj_idx(obj_idx),
    .obj_center(obj_center),
    .obj_radius_sq(obj_radius_sq),
    .obj_color(obj_color),
    .obj_last(obj_last),
    .trace_done(trace_done),
    .color(color),
    .pix_h_out(trace_h),
    .pix_v_out(trace_v)
  );

  pixel_packer packer (
    .clk(clk),
    .trace_done(trace_done),
    .color(color),
    .pix_h_in(trace_h),
    .pix_v_in(trace_v),
    .rtx_pixel(rtx_pixel),
    .pixel_h(pixel_h),
    .pixel_v(pixel_v),
    .ray_done(ray_done)
  );

endmodule

`default_nettype wire

// File: hw/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_packer (
  input  wire clk,
  input  wire trace_done,
  input  wire rtx_pkg::fp24_color_t color,
  input  wire [rtx_pkg::PIX_H_BITS-1:0] pix_h_in,
  input  wire [rtx_pkg::PIX_V_BITS-1:0] pix_v_in,
  output logic [15:0] rtx_pixel,
  output logic [rtx_pkg::PIX_H_BITS-1:0] pixel_h,
  output logic [rtx_pkg::PIX_V_BITS-1:0] pixel_v,
  output logic ray_done
);
  import rtx_pkg::*;

  function automatic fp24_t clip(input fp24_t v);
    if (v[23]) begin
      return '0;
    end
    // Positive floats order like unsigned integers
    return (v[22:0] > FP24_ONE[22:0]) ? FP24_ONE : v;
  endfunction

  // floor(v * 2^bits), saturated
  function automatic logic [5:0] to_fixed(input fp24_t v, input int bits);
    int          sh;
    logic [16:0] n;
    sh = int'(v[22:16]) - 63 + bits;
    if (v[22:16] == 7'd0 || sh < 0) begin
      return '0;
    end
    n = {1'b1, v[15:0]} >> (16 - sh);
    if (n >= 17'(1 << bits)) begin
      n = 17'((1 << bits) - 1);
    end
    return n[5:0];
  endfunction

  fp24_color_t           clipped;
  logic                  done_q;
  logic [PIX_H_BITS-1:0] h_q;
  logic [PIX_V_BITS-1:0] v_q;
  logic [5:0]            r_n, g_n, b_n;

  always_comb begin
    r_n = to_fixed(clipped.r, 5);
    g_n = to_fixed(clipped.g, 6);
    b_n = to_fixed(clipped.b, 5);
  end

  always_ff @(posedge clk) begin
    clipped.r <= clip(color.r);
    clipped.g <= clip(color.g);
    clipped.b <= clip(color.b);
    done_q <= trace_done;
    h_q <= pix_h_in;
    v_q <= pix_v_in;

    rtx_pixel <= {b_n[4:0], g_n, r_n[4:0]};
    ray_done <= done_q;
    pixel_h <= h_q;
    pixel_v <= v_q;
  end

  a_done_delay: assert property (@(posedge clk)
    !$isunknown($past(trace_done, 2)) |-> ray_done == $past(trace_done, 2));

endmodule

`default_nettype wire

// File: hw/ray_tracer.sv
`timescale 1ns/1ps
`default_nettype none

module ray_tracer (
  input  wire clk,
  input  wire rst,
  input  wire ray_valid,
  input  wire [rtx_pkg::PIX_H_BITS-1:0] pix_h_in,
  input  wire [rtx_pkg::PIX_V_BITS-1:0] pix_v_in,
  input  wire rtx_pkg::fp24_vec3_t ray_dir,
  output logic [rtx_pkg::OBJ_IDX_BITS-1:0] obj_idx,
  input  wire rtx_pkg::fp24_vec3_t obj_center,
  input  wire rtx_pkg::fp24_t obj_radius_sq,
  input  wire rtx_pkg::fp24_color_t obj_color,
  input  wire obj_last,
  output logic trace_done,
  output rtx_pkg::fp24_color_t color,
  output logic [rtx_pkg::PIX_H_BITS-1:0] pix_h_out,
  output logic [rtx_pkg::PIX_V_BITS-1:0] pix_v_out
);
  import rtx_pkg::*;

  logic       busy;
  logic [3:0] step;
  fp24_t      mul_a, mul_b, p;
  fp24_t      add_a, add_b, s;
  logic       add_sub;
  fp24_t      tmp, b_val, cc_val;
  logic       hit;

  fp24_mul mul (.clk(clk), .a(mul_a), .b(mul_b), .p(p));
  fp24_add add (.clk(clk), .a(add_a), .b(add_b), .sub(add_sub), .s(s));

  // Step 0 waits for the scene read; products land one step after issue,
  // sums one step after that
  always_comb begin
    mul_a = '0;
    mul_b = '0;
    add_a = tmp;
    add_b = p;
    add_sub = 1'b0;
    case (step)
      4'd1: {mul_a, mul_b} = {obj_center.x, ray_dir.x};
      4'd2: {mul_a, mul_b} = {obj_center.y, ray_dir.y};
      4'd3: {mul_a, mul_b} = {obj_center.z, ray_dir.z};
      4'd4: begin
        {mul_a, mul_b} = {obj_center.x, obj_center.x};
        add_a = s;
      end
      4'd5: {mul_a, mul_b} = {obj_center.y, obj_center.y};
      4'd6: {mul_a, mul_b} = {obj_center.z, obj_center.z};
      4'd7: begin
        {mul_a, mul_b} = {ray_dir.x, ray_dir.x};
        add_a = s;
      end
      4'd8: begin
        // |c|^2 - r^2
        {mul_a, mul_b} = {ray_dir.y, ray_dir.y};
        add_a = s;
        add_b = obj_radius_sq;
        add_sub = 1'b1;
      end
      4'd9: {mul_a, mul_b} = {ray_dir.z, ray_dir.z};
      4'd10: begin
        {mul_a, mul_b} = {b_val, b_val};
        add_a = s;
      end
      4'd11: {mul_a, mul_b} = {s, cc_val};
      4'd12: add_sub = 1'b1;
      default: ;
    endcase
  end

  // b > 0 and discriminant not negative
  assign hit = !b_val[23] && (b_val[22:16] != 7'd0) && !s[23];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      step <= '0;
      obj_idx <= '0;
      trace_done <= 1'b0;
    end else begin
      trace_done <= 1'b0;
      if (ray_valid) begin
        busy <= 1'b1;
        step <= '0;
        obj_idx <= '0;
      end else if (busy) begin
        if (step == 4'd13) begin
          step <= '0;
          if (hit || obj_last) begin
            busy <= 1'b0;
            trace_done <= 1'b1;
            obj_idx <= '0;
          end else begin
            obj_idx <= obj_idx + 1'b1;
          end
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      case (step)
        4'd2, 4'd5, 4'd8, 4'd11: tmp <= p;
        default: ;
      endcase
      if (step == 4'd5) begin
        b_val <= s;
      end
      if (step == 4'd9) begin
        cc_val <= s;
      end
      if (step == 4'd13 && (hit || obj_last)) begin
        color <= hit ? obj_color : BACKGROUND;
        pix_h_out <= pix_h_in;
        pix_v_out <= pix_v_in;
      end
    end
  end

  a_stop_at_last: assert property (@(posedge clk) disable iff (rst)
    ($changed(obj_idx) && obj_idx != '0) |-> !$past(obj_last));

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    ray_valid |-> !busy);

endmodule

`default_nettype wire

// File: hw/ray_caster.sv
`timescale 1ns/1ps
`default_nettype none

module ray_caster (
  input  wire clk,
  input  wire rst,
  input  wire new_ray,
  output logic [rtx_pkg::PIX_H_BITS-1:0] pix_h,
  output logic [rtx_pkg::PIX_V_BITS-1:0] pix_v,
  output rtx_pkg::fp24_vec3_t ray_dir,
  output logic ray_valid
);
  import rtx_pkg::*;

  function automatic fp24_t int_to_fp24(input logic signed [15:0] n);
    logic [15:0] mag;
    logic [15:0] norm;
    logic [4:0]  lz;
    mag = n[15] ? 16'(-n) : n;
    lz = 5'd16;
    for (int i = 0; i < 16; i++) begin
      if (mag[i]) begin
        lz = 5'(15 - i);
      end
    end
    norm = mag << lz;
    if (mag == '0) begin
      return '0;
    end
    // Leading one sits at bit 15 after the shift, so exponent is 63 + 15 - lz
    return {n[15], 7'(7'd78 - {2'b00, lz}), norm[14:0], 1'b0};
  endfunction

  logic                  started;
  logic                  s1_valid;
  logic [PIX_H_BITS-1:0] h_next;
  logic [PIX_V_BITS-1:0] v_next;
  logic signed [15:0]    ofs_x, ofs_y;

  // First ray after reset stays at (0, 0)
  always_comb begin
    h_next = pix_h;
    v_next = pix_v;
    if (started) begin
      if (pix_h == PIX_H_BITS'(SCREEN_W - 1)) begin
        h_next = '0;
        v_next = (pix_v == PIX_V_BITS'(SCREEN_H - 1)) ? '0 : pix_v + 1'b1;
      end else begin
        h_next = pix_h + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      started <= 1'b0;
      pix_h <= '0;
      pix_v <= '0;
      s1_valid <= 1'b0;
      ray_valid <= 1'b0;
    end else begin
      s1_valid <= new_ray;
      ray_valid <= s1_valid;
      if (new_ray) begin
        started <= 1'b1;
        pix_h <= h_next;
        pix_v <= v_next;
      end
    end
  end

  // Stage 1 signed offsets, stage 2 float conversion
  always_ff @(posedge clk) begin
    if (new_ray) begin
      ofs_x <= 16'(int'(h_next) - SCREEN_W / 2);
      ofs_y <= 16'(SCREEN_H / 2 - int'(v_next));
    end
    if (s1_valid) begin
      ray_dir.x <= int_to_fp24(ofs_x);
      ray_dir.y <= int_to_fp24(ofs_y);
      ray_dir.z <= int_to_fp24(16'(SCREEN_W / 2));
    end
  end

  a_single_valid: assert property (@(posedge clk) disable iff (rst)
    ray_valid |=> !ray_valid);

endmodule

`default_nettype wire

// File: hw/fp24_add.sv
`timescale 1ns/1ps
`default_nettype none

module fp24_add (
  input  wire clk,
  input  wire rtx_pkg::fp24_t a,
  input  wire rtx_pkg::fp24_t b,
  input  wire sub,
  output rtx_pkg::fp24_t s
);
  import rtx_pkg::*;

  function automatic logic [4:0] lzc20(input logic [19:0] v);
    logic [4:0] n;
    n = 5'd20;
    // Highest set bit wins
    for (int i = 0; i < 20; i++) begin
      if (v[i]) begin
        n = 5'(19 - i);
      end
    end
    return n;
  endfunction

  logic              swap;
  logic              l_s, s_s;
  logic [6:0]        l_e, s_e;
  logic [15:0]       l_m, s_m;
  logic [19:0]       l_x, s_x;
  logic [19:0]       sum, norm;
  logic [4:0]        lz;
  logic signed [9:0] e_res;
  fp24_t             s_next;

  always_comb begin
    // Larger magnitude goes first so the difference never goes negative
    swap = b[22:0] > a[22:0];
    if (swap) begin
      {l_s, l_e, l_m} = {b[23] ^ sub, b[22:0]};
      {s_s, s_e, s_m} = a;
    end else begin
      {l_s, l_e, l_m} = a;
      {s_s, s_e, s_m} = {b[23] ^ sub, b[22:0]};
    end

    // Carry bit, hidden bit, mantissa, two guard bits
    l_x = (l_e == 7'd0) ? '0 : {2'b01, l_m, 2'b00};
    s_x = (s_e == 7'd0) ? '0 : ({2'b01, s_m, 2'b00} >> (l_e - s_e));

    sum = (l_s == s_s) ? l_x + s_x : l_x - s_x;
    lz = lzc20(sum);
    norm = sum << lz;
    e_res = $signed({3'b000, l_e}) + 10'sd1 - $signed({5'b00000, lz});

    if (sum == '0 || e_res <= 0) begin
      s_next = '0;
    end else if (e_res > 10'sd127) begin
      s_next = {l_s, 7'h7f, 16'hffff};
    end else begin
      s_next = {l_s, e_res[6:0], norm[18:3]};
    end
  end

  always_ff @(posedge clk) begin
    s <= s_next;
  end

endmodule

`default_nettype wire

// File: hw/fp24_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fp24_mul (
  input  wire clk,
  input  wire rtx_pkg::fp24_t a,
  input  wire rtx_pkg::fp24_t b,
  output rtx_pkg::fp24_t p
);
  import rtx_pkg::*;

  logic              sign;
  logic [33:0]       prod;
  logic signed [9:0] e_res;
  fp24_t             p_next;

  always_comb begin
    sign = a[23] ^ b[23];
    // Hidden bits restored, 17 x 17 product
    prod = {1'b1, a[15:0]} * {1'b1, b[15:0]};
    e_res = $signed({3'b000, a[22:16]}) + $signed({3'b000, b[22:16]}) - 10'sd63
            + $signed({9'b0, prod[33]});

    if (a[22:16] == 7'd0 || b[22:16] == 7'd0 || e_res <= 0) begin
      // Zero operand or underflow
      p_next = '0;
    end else if (e_res > 10'sd127) begin
      p_next = {sign, 7'h7f, 16'hffff};
    end else if (prod[33]) begin
      p_next = {sign, e_res[6:0], prod[32:17]};
    end else begin
      p_next = {sign, e_res[6:0], prod[31:16]};
    end
  end

  always_ff @(posedge clk) begin
    p <= p_next;
  end

endmodule

`default_nettype wire

// File: hw/rtx_pkg.sv
`default_nettype none

package rtx_pkg;

  // fp24 layout: sign, 7-bit exponent (bias 63), 16-bit mantissa
  typedef logic [23:0] fp24_t;

  typedef struct packed {
    fp24_t x;
    fp24_t y;
    fp24_t z;
  } fp24_vec3_t;

  typedef struct packed {
    fp24_t r;
    fp24_t g;
    fp24_t b;
  } fp24_color_t;

  localparam fp24_t FP24_ONE = 24'h3f0000;

  // Screen size, kept small for simulation
  localparam int SCREEN_W = 16;
  localparam int SCREEN_H = 8;

  localparam int PIX_H_BITS = $clog2(SCREEN_W);
  localparam int PIX_V_BITS = $clog2(SCREEN_H);

  // Scene buffer
  localparam int SCENE_DEPTH = 8;
  localparam int OBJ_IDX_BITS = $clog2(SCENE_DEPTH);

  // Dim blue, (0, 0, 0.25)
  localparam fp24_color_t BACKGROUND = '{
    r: 24'h000000,
    g: 24'h000000,
    b: 24'h3d0000
  };

endpackage

`default_nettype wire
